//--- rtl/fib_pkg.sv
// ####################################################################
// // Definitions shared by the FIB learner, lookup engine and table
// // Modules import this package inside their body where needed
// ####################################################################

package fib_pkg;

    // Name and length field widths
    localparam int NAME_BITS  = 64;
    localparam int LEN_BITS   = 6;
    localparam int NAME_BYTES = NAME_BITS / 8;

    // One name, seen as a word for masking and hashing
    // or as bytes for the wire, most significant byte first
    typedef union packed {
        logic [NAME_BITS-1:0]         word;
        logic [0:NAME_BYTES-1][7:0]   bytes;
    } fib_name_u;

    // Keep the leading len bits of a name
    // Length 0 gives an all-zero mask
    function automatic logic [NAME_BITS-1:0] fib_prefix_mask(
        input logic [LEN_BITS-1:0] len
    );
        return ~({NAME_BITS{1'b1}} >> len);
    endfunction

    // XOR of the four 16-bit quarters of an already masked name
    // Callers take the low bits as the table index
    function automatic logic [15:0] fib_fold16(
        input logic [NAME_BITS-1:0] name
    );
        logic [15:0] fold;
        fold = name[63:48];
        fold = fold ^ name[47:32];
        fold = fold ^ name[31:16];
        fold = fold ^ name[15:0];
        return fold;
    endfunction

endpackage

//--- rtl/fib_byte_if.sv
// ####################################################################
// // Byte stream between FIB blocks, valid/ready with end of packet
// // A byte moves on a cycle where valid and ready are both high
// ####################################################################

`timescale 1ns/1ps

interface fib_byte_if;

    // Source holds data and last stable while valid waits for ready
    logic       valid;
    logic       ready;
    logic [7:0] data;
    logic       last;

    // Producer side
    modport source (
        output valid, data, last,
        input  ready
    );

    // Consumer side
    modport sink (
        input  valid, data, last,
        output ready
    );

endinterface

//--- rtl/fib_valid_table.sv
// ####################################################################
// // Hashed table of prefix valid bits, one 64-bit word per index
// // Bit n of a word marks a prefix of length n; no tags are kept
// // Cleared by a sweep after reset, then table_ready goes high
// ####################################################################

`timescale 1ns/1ps

module fib_valid_table #(
    parameter int HASH_BITS = 10
) (
    input  logic                         clk,
    input  logic                         rst,
    // Write port, from the learner
    input  logic                         wr_en,
    input  logic [HASH_BITS-1:0]         wr_index,
    input  logic [fib_pkg::LEN_BITS-1:0] wr_len,
    // Read port, from the lookup engine
    input  logic                         rd_en,
    input  logic [HASH_BITS-1:0]         rd_index,
    input  logic [fib_pkg::LEN_BITS-1:0] rd_len,
    output logic                         rd_hit,
    output logic                         table_ready
);
    import fib_pkg::*;

    localparam int DEPTH = 1 << HASH_BITS;

    logic [NAME_BITS-1:0] valid_mem [DEPTH];
    logic [HASH_BITS-1:0] clr_index;

    // Clearing sweep, one index per cycle
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            clr_index   <= '0;
            table_ready <= 1'b0;
        end else if (!table_ready) begin
            clr_index <= clr_index + 1'b1;
            // Last index cleared this cycle
            if (&clr_index) begin
                table_ready <= 1'b1;
            end
        end
    end

    // Storage, sweep has priority over learning
    always_ff @(posedge clk) begin
        if (!table_ready) begin
            valid_mem[clr_index] <= '0;
        end else if (wr_en) begin
            valid_mem[wr_index][wr_len] <= 1'b1;
        end
        // Registered read, hit valid the cycle after rd_en
        if (rd_en) begin
            rd_hit <= valid_mem[rd_index][rd_len];
        end
    end

endmodule

//--- rtl/fib_rx_learn.sv
// ####################################################################
// // Data packet learner: takes 9 bytes from SPI, installs the prefix
// // in the valid table, then forwards the packet unchanged on tx
// ####################################################################

`timescale 1ns/1ps

module fib_rx_learn #(
    parameter int HASH_BITS = 10
) (
    input  logic                         clk,
    input  logic                         rst,
    // Incoming bytes from SPI
    input  logic                         rx_valid,
    input  logic [7:0]                   rx_data,
    output logic                         rx_ready,
    // Table write port
    input  logic                         table_ready,
    output logic                         wr_en,
    output logic [HASH_BITS-1:0]         wr_index,
    output logic [fib_pkg::LEN_BITS-1:0] wr_len,
    // Forwarded packet
    fib_byte_if.source                   tx
);
    import fib_pkg::*;

    // Receive, hash, then replay
    localparam logic [1:0] S_RECV = 2'd0;
    localparam logic [1:0] S_HASH = 2'd1;
    localparam logic [1:0] S_SEND = 2'd2;

    logic [1:0]           state;
    logic [3:0]           byte_cnt;
    logic [2:0]           byte_sel;
    logic [7:0]           meta;
    fib_name_u            name;
    logic [NAME_BITS-1:0] masked;
    logic [15:0]          fold;

    // Count 0 is the metadata byte, 1..8 the name bytes
    assign byte_sel = 3'(byte_cnt - 4'd1);

    // Prefix of the buffered name and its hash
    assign masked = name.word & fib_prefix_mask(meta[LEN_BITS-1:0]);
    assign fold   = fib_fold16(masked);

    // Only accept while collecting and the table is swept
    assign rx_ready = (state == S_RECV) && table_ready;

    // Control
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= S_RECV;
            byte_cnt <= '0;
            wr_en    <= 1'b0;
        end else begin
            wr_en <= 1'b0;
            case (state)
                S_RECV: begin
                    if (rx_valid && rx_ready) begin
                        if (byte_cnt == 4'(NAME_BYTES)) begin
                            byte_cnt <= '0;
                            state    <= S_HASH;
                        end else begin
                            byte_cnt <= byte_cnt + 1'b1;
                        end
                    end
                end
                S_HASH: begin
                    // Write lands in the first cycle of the replay
                    wr_en <= 1'b1;
                    state <= S_SEND;
                end
                S_SEND: begin
                    if (tx.valid && tx.ready) begin
                        if (tx.last) begin
                            byte_cnt <= '0;
                            state    <= S_RECV;
                        end else begin
                            byte_cnt <= byte_cnt + 1'b1;
                        end
                    end
                end
                default: state <= S_RECV;
            endcase
        end
    end

    // Packet buffer and table write address
    always_ff @(posedge clk) begin
        if (state == S_RECV && rx_valid && rx_ready) begin
            if (byte_cnt == 4'd0) begin
                meta <= rx_data;
            end else begin
                name.bytes[byte_sel] <= rx_data;
            end
        end
        if (state == S_HASH) begin
            wr_index <= fold[HASH_BITS-1:0];
            wr_len   <= meta[LEN_BITS-1:0];
        end
    end

    // Replay the buffer as received
    assign tx.valid = (state == S_SEND);
    assign tx.data  = (byte_cnt == 4'd0) ? meta : name.bytes[byte_sel];
    assign tx.last  = (byte_cnt == 4'(NAME_BYTES));

endmodule

//--- rtl/fib_lpm_lookup.sv
// ####################################################################
// // Longest prefix search for PIT requests, one bit shorter per probe
// // Result goes out as a 17-byte interest packet on tx
// ####################################################################

`timescale 1ns/1ps

module fib_lpm_lookup #(
    parameter int HASH_BITS = 10
) (
    input  logic                          clk,
    input  logic                          rst,
    // Request from the PIT
    input  logic                          pit_valid,
    input  logic [fib_pkg::NAME_BITS-1:0] pit_name,
    input  logic [7:0]                    pit_meta,
    output logic                          pit_ready,
    // Table read port
    input  logic                          table_ready,
    input  logic                          rd_hit,
    output logic                          rd_en,
    output logic [HASH_BITS-1:0]          rd_index,
    output logic [fib_pkg::LEN_BITS-1:0]  rd_len,
    // Interest packet out
    fib_byte_if.source                    tx
);
    import fib_pkg::*;

    localparam logic [1:0] S_IDLE  = 2'd0;
    localparam logic [1:0] S_HASH  = 2'd1;
    localparam logic [1:0] S_PROBE = 2'd2;
    localparam logic [1:0] S_SEND  = 2'd3;

    logic [1:0]           state;
    logic                 checking;
    logic                 probe_done;
    logic [LEN_BITS-1:0]  len;
    logic [LEN_BITS-1:0]  next_len;
    logic [7:LEN_BITS]    meta_hi;
    fib_name_u            req_name;
    fib_name_u            probe_name;
    logic [NAME_BITS-1:0] probe_masked;
    logic [15:0]          probe_fold;
    logic [4:0]           byte_cnt;
    logic [2:0]           byte_sel;

    assign pit_ready = (state == S_IDLE) && table_ready;

    // A previous probe result is waiting in rd_hit
    // Stop on a hit, or when length 0 has been probed
    assign probe_done = checking && (rd_hit || len == '0);
    assign next_len   = checking ? len - 1'b1 : len;

    // Next prefix to probe and its table index
    assign probe_masked = req_name.word & fib_prefix_mask(next_len);
    assign probe_fold   = fib_fold16(probe_masked);

    // Table read in the cycle after the hash is registered
    assign rd_en  = (state == S_PROBE);
    assign rd_len = len;

    // Control
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= S_IDLE;
            checking <= 1'b0;
            byte_cnt <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (pit_valid && pit_ready) begin
                        checking <= 1'b0;
                        state    <= S_HASH;
                    end
                end
                S_HASH: begin
                    state <= probe_done ? S_SEND : S_PROBE;
                end
                S_PROBE: begin
                    checking <= 1'b1;
                    state    <= S_HASH;
                end
                S_SEND: begin
                    if (tx.valid && tx.ready) begin
                        if (tx.last) begin
                            byte_cnt <= '0;
                            state    <= S_IDLE;
                        end else begin
                            byte_cnt <= byte_cnt + 1'b1;
                        end
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // Request capture and probe registers
    always_ff @(posedge clk) begin
        if (state == S_IDLE && pit_valid && pit_ready) begin
            req_name.word <= pit_name;
            meta_hi       <= pit_meta[7:LEN_BITS];
            len           <= pit_meta[LEN_BITS-1:0];
        end
        if (state == S_HASH && !probe_done) begin
            len             <= next_len;
            probe_name.word <= probe_masked;
            rd_index        <= probe_fold[HASH_BITS-1:0];
        end
    end

    // Bytes 1..8 full name, 9..16 matched prefix; same low three bits
    assign byte_sel = 3'(byte_cnt - 5'd1);

    // After the search, probe_name holds the name masked to the found length
    assign tx.valid = (state == S_SEND);
    always_comb begin
        if (byte_cnt == 5'd0) begin
            tx.data = {meta_hi, len};
        end else if (byte_cnt <= 5'(NAME_BYTES)) begin
            tx.data = req_name.bytes[byte_sel];
        end else begin
            tx.data = probe_name.bytes[byte_sel];
        end
    end
    assign tx.last = (byte_cnt == 5'(2 * NAME_BYTES));

endmodule

//--- rtl/fib_tx_merge.sv
// ####################################################################
// // Merges two byte streams onto one, a whole packet at a time
// // Round robin between sources when both wait at a packet boundary
// ####################################################################

`timescale 1ns/1ps

module fib_tx_merge (
    input  logic       clk,
    input  logic       rst,
    // Sources
    fib_byte_if.sink   a,
    fib_byte_if.sink   b,
    // Merged stream
    fib_byte_if.source out
);

    // busy: a packet is in flight from the source in sel
    // sel also remembers who was served last
    logic busy;
    logic sel;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy <= 1'b0;
            // Source a wins the first tie
            sel  <= 1'b1;
        end else if (!busy) begin
            if (a.valid && b.valid) begin
                sel  <= ~sel;
                busy <= 1'b1;
            end else if (a.valid) begin
                sel  <= 1'b0;
                busy <= 1'b1;
            end else if (b.valid) begin
                sel  <= 1'b1;
                busy <= 1'b1;
            end
        end else if (out.valid && out.ready && out.last) begin
            // Release only once the last byte has gone
            busy <= 1'b0;
        end
    end

    // Straight through from the granted source
    assign out.valid = busy && (sel ? b.valid : a.valid);
    assign out.data  = sel ? b.data : a.data;
    assign out.last  = sel ? b.last : a.last;

    // The other source sees no ready and holds its byte
    assign a.ready = busy && !sel && out.ready;
    assign b.ready = busy && sel && out.ready;

endmodule

//--- rtl/fib_table_top.sv
// ####################################################################
// // FIB top level: valid table, learner, lookup engine and merger
// // Data packets in on rx, PIT requests in, all packets out on tx
// ####################################################################

`timescale 1ns/1ps

module fib_table_top #(
    parameter int HASH_BITS = 10
) (
    input  logic                          clk,
    input  logic                          rst,
    // Data packets from SPI
    input  logic                          rx_valid,
    input  logic [7:0]                    rx_data,
    output logic                          rx_ready,
    // PIT requests
    input  logic                          pit_valid,
    input  logic [fib_pkg::NAME_BITS-1:0] pit_name,
    input  logic [7:0]                    pit_meta,
    output logic                          pit_ready,
    // Merged packets to SPI
    output logic                          tx_valid,
    output logic [7:0]                    tx_data,
    output logic                          tx_last,
    input  logic                          tx_ready
);
    import fib_pkg::*;

    // Table ports
    logic                 wr_en;
    logic [HASH_BITS-1:0] wr_index;
    logic [LEN_BITS-1:0]  wr_len;
    logic                 rd_en;
    logic [HASH_BITS-1:0] rd_index;
    logic [LEN_BITS-1:0]  rd_len;
    logic                 rd_hit;
    logic                 table_ready;

    // Learner and lookup streams into the merger, merger out to tx
    fib_byte_if learn_tx ();
    fib_byte_if lookup_tx ();
    fib_byte_if merge_tx ();

    fib_valid_table #(.HASH_BITS(HASH_BITS)) u_table (
        .clk(clk), .rst(rst),
        .wr_en(wr_en), .wr_index(wr_index), .wr_len(wr_len),
        .rd_en(rd_en), .rd_index(rd_index), .rd_len(rd_len),
        .rd_hit(rd_hit), .table_ready(table_ready)
    );

    fib_rx_learn #(.HASH_BITS(HASH_BITS)) u_learn (
        .clk(clk), .rst(rst),
        .rx_valid(rx_valid), .rx_data(rx_data), .rx_ready(rx_ready),
        .table_ready(table_ready),
        .wr_en(wr_en), .wr_index(wr_index), .wr_len(wr_len),
        .tx(learn_tx.source)
    );

    fib_lpm_lookup #(.HASH_BITS(HASH_BITS)) u_lookup (
        .clk(clk), .rst(rst),
        .pit_valid(pit_valid), .pit_name(pit_name), .pit_meta(pit_meta),
        .pit_ready(pit_ready),
        .table_ready(table_ready), .rd_hit(rd_hit),
        .rd_en(rd_en), .rd_index(rd_index), .rd_len(rd_len),
        .tx(lookup_tx.source)
    );

    fib_tx_merge u_merge (
        .clk(clk), .rst(rst),
        .a(learn_tx.sink), .b(lookup_tx.sink),
        .out(merge_tx.source)
    );

    // Merged stream onto the plain tx ports
    assign tx_valid       = merge_tx.valid;
    assign tx_data        = merge_tx.data;
    assign tx_last        = merge_tx.last;
    assign merge_tx.ready = tx_ready;

endmodule

//--- bench/fib_clock_gen.sv
// ####################################################################
// // Testbench clock and reset for the FIB top level
// // 20 ns period, active-high reset held for the first 16 cycles
// ####################################################################

`timescale 1ns/1ps

module fib_clock_gen #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 16
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // Release on a falling edge, half a cycle away from the flops
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

//--- bench/fib_table_asserts.sv
// ####################################################################
// // Protocol assertions on the FIB top level, attached with bind
// // The testbench adds fail_count to its error count at the end
// ####################################################################

`timescale 1ns/1ps

module fib_table_asserts (
    input logic       clk,
    input logic       rst,
    input logic       tx_valid,
    input logic       tx_ready,
    input logic [7:0] tx_data,
    input logic       tx_last,
    input logic       rx_ready,
    input logic       table_ready,
    input logic       rd_en,
    input logic       wr_en
);

    int fail_count = 0;

    // A stalled byte stays on tx unchanged until taken
    tx_held: assert property (@(posedge clk) disable iff (rst)
        tx_valid && !tx_ready |=> tx_valid && $stable(tx_data) && $stable(tx_last))
        else begin
            $error("tx byte changed or dropped while stalled");
            fail_count++;
        end

    // The learner writes the table during its replay and never while it takes bytes
    write_in_replay: assert property (@(posedge clk) disable iff (rst)
        wr_en |-> !rx_ready)
        else begin
            $error("table write while the learner still accepted rx bytes");
            fail_count++;
        end

    // Table ports used only after the sweep
    table_access: assert property (@(posedge clk) disable iff (rst)
        (rd_en || wr_en) |-> table_ready)
        else begin
            $error("table read or write during the clearing sweep");
            fail_count++;
        end

endmodule

//--- bench/fib_tb.sv
// ####################################################################
// // Testbench for the FIB top level that drives rx data and PIT requests
// // and checks every tx packet against a model of the valid table
// ####################################################################

`timescale 1ns/1ps

module fib_tb;

    localparam int HASH_BITS = 10;
    // Cycles any single wait may take
    localparam int LIMIT = 3000;

    logic         clk;
    logic         rst;
    logic         rx_valid  = 1'b0;
    logic [7:0]   rx_data   = '0;
    logic         rx_ready;
    logic         pit_valid = 1'b0;
    logic [63:0]  pit_name  = '0;
    logic [7:0]   pit_meta  = '0;
    logic         pit_ready;
    logic         tx_valid;
    logic [7:0]   tx_data;
    logic         tx_last;
    logic         tx_ready  = 1'b1;

    // Model table where bit n of a row marks prefix length n
    logic [63:0]  ref_mem [1 << HASH_BITS] = '{default: '0};
    // Expected packets of each source in order and right aligned
    logic [135:0] data_q [$];
    logic [135:0] interest_q [$];
    // Packet being collected from tx
    logic [135:0] pkt          = '0;
    int           pkt_len      = 0;
    integer       seed         = 32'h821407d2;
    logic         random_ready = 1'b0;
    logic         timed_out    = 1'b0;
    int           errors       = 0;
    int           test_count   = 0;
    int           failed_tests = 0;
    string        test_name    = "reset";

    fib_clock_gen clock_gen (.clk(clk), .rst(rst));

    fib_table_top #(.HASH_BITS(HASH_BITS)) DUT (
        .clk(clk), .rst(rst),
        .rx_valid(rx_valid), .rx_data(rx_data), .rx_ready(rx_ready),
        .pit_valid(pit_valid), .pit_name(pit_name), .pit_meta(pit_meta),
        .pit_ready(pit_ready),
        .tx_valid(tx_valid), .tx_data(tx_data), .tx_last(tx_last), .tx_ready(tx_ready)
    );

    bind fib_table_top fib_table_asserts u_asserts (
        .clk(clk), .rst(rst), .tx_valid(tx_valid), .tx_ready(tx_ready),
        .tx_data(tx_data), .tx_last(tx_last), .rx_ready(rx_ready),
        .table_ready(table_ready), .rd_en(rd_en), .wr_en(wr_en)
    );

    // Keeps the leading len bits of a name
    function automatic logic [63:0] mask_name(input logic [63:0] name, input int len);
        logic [63:0] keep;
        keep = '0;
        for (int i = 0; i < len; i++) begin
            keep[63 - i] = 1'b1;
        end
        return name & keep;
    endfunction

    // Row of a masked name from the XOR of its 16-bit quarters
    function automatic int row_of(input logic [63:0] masked);
        logic [15:0] fold;
        fold = '0;
        for (int q = 0; q < 4; q++) begin
            fold = fold ^ masked[16 * q +: 16];
        end
        return int'(fold[HASH_BITS-1:0]);
    endfunction

    // Longest installed prefix in the model and the 17 expected bytes
    function automatic logic [135:0] interest_pkt(input logic [63:0] name,
                                                  input logic [7:0] meta);
        int found;
        found = meta[5:0];
        while (found > 0 && !ref_mem[row_of(mask_name(name, found))][found]) begin
            found--;
        end
        return {meta[7:6], 6'(found), name, mask_name(name, found)};
    endfunction

    // One cycle of a bounded wait
    task automatic wait_cycle(inout int count, input string what);
        count++;
        if (count > LIMIT) begin
            $display("Timeout in test %s: %s", test_name, what);
            timed_out = 1'b1;
        end
        @(negedge clk);
    endtask

    // Model learns the prefix before the packet goes out on rx
    task automatic send_data(input logic [63:0] name, input logic [7:0] meta);
        logic [71:0] bytes;
        int count;
        bytes = {meta, name};
        count = 0;
        ref_mem[row_of(mask_name(name, meta[5:0]))][meta[5:0]] = 1'b1;
        data_q.push_back(136'(bytes));
        for (int i = 0; i < 9; i++) begin
            @(negedge clk);
            rx_valid = 1'b1;
            rx_data  = bytes[71 - 8 * i -: 8];
            // rx_ready only moves on a rising edge
            while (!rx_ready && !timed_out) begin
                wait_cycle(count, "rx_ready stayed low");
            end
        end
        @(negedge clk);
        rx_valid = 1'b0;
    endtask

    task automatic send_request(input logic [63:0] name, input logic [7:0] meta);
        int count;
        count = 0;
        interest_q.push_back(interest_pkt(name, meta));
        @(negedge clk);
        pit_valid = 1'b1;
        pit_name  = name;
        pit_meta  = meta;
        while (!pit_ready && !timed_out) begin
            wait_cycle(count, "pit_ready stayed low");
        end
        @(negedge clk);
        pit_valid = 1'b0;
    endtask

    task automatic wait_drained();
        int count;
        count = 0;
        while ((data_q.size() > 0 || interest_q.size() > 0) && !timed_out) begin
            wait_cycle(count, "expected packets never came out on tx");
        end
    endtask

    task automatic check_packet();
        logic [135:0] want;
        if (pkt_len == 9 && data_q.size() > 0) begin
            want = data_q.pop_front();
        end else if (pkt_len == 17 && interest_q.size() > 0) begin
            want = interest_q.pop_front();
        end else begin
            $display("Unexpected tx packet of %0d bytes in test %s", pkt_len, test_name);
            errors++;
            return;
        end
        assert (pkt == want) else begin
            $display("CHECK FAILED %s: expected %h, actual %h", test_name, want, pkt);
            errors++;
        end
    endtask

    task automatic finish_test(input int errors_before);
        logic ok;
        ok = (errors == errors_before) && !timed_out;
        test_count++;
        if (!ok) begin
            failed_tests++;
        end
        $display("Test %s: %s", test_name, ok ? "ok" : "FAILED");
    endtask

    // Receive side sets ready for the coming edge
    // Bytes are split into packets at tx_last
    always @(negedge clk) begin
        tx_ready = random_ready ? 1'($random(seed)) : 1'b1;
        if (tx_valid && tx_ready) begin
            pkt = {pkt[127:0], tx_data};
            pkt_len++;
            if (tx_last) begin
                check_packet();
                pkt     = '0;
                pkt_len = 0;
            end
        end
    end

    initial begin
        int base;
        int count;
        logic [63:0] name;
        logic [63:0] burst [12];
        base  = errors;
        count = 0;
        while (rst !== 1'b0 && !timed_out) begin
            wait_cycle(count, "reset never released");
        end
        assert (!tx_valid && !rx_ready && !pit_ready) else begin
            $display("CHECK FAILED %s: expected tx_valid/rx_ready/pit_ready 000, actual %b%b%b",
                     test_name, tx_valid, rx_ready, pit_ready);
            errors++;
        end
        count = 0;
        while (!(rx_ready && pit_ready) && !timed_out) begin
            wait_cycle(count, "rx_ready and pit_ready never rose after the sweep");
        end
        finish_test(base);

        test_name = "empty table miss";
        base = errors;
        send_request({$random(seed), $random(seed)}, 8'hE5);
        wait_drained();
        finish_test(base);

        test_name = "forwarding";
        base = errors;
        send_data({$random(seed), $random(seed)}, 8'h5C);
        wait_drained();
        finish_test(base);

        // Lengths 16 and 40 from one name then queries of 48 and 30
        test_name = "longest match";
        base = errors;
        name = 64'hA5C3_1E77_0F92_4B68;
        send_data(name, 8'd16);
        wait_drained();
        send_data(name, 8'd40);
        wait_drained();
        send_request(name, 8'd48);
        send_request(name, 8'h80 | 8'd30);
        wait_drained();
        finish_test(base);

        // Odd rounds query the name just installed
        test_name = "random lookups";
        base = errors;
        for (int k = 0; k < 24; k++) begin
            name = {$random(seed), $random(seed)};
            send_data(name, 8'($random(seed)));
            wait_drained();
            if (k % 2 == 0) begin
                name = {$random(seed), $random(seed)};
            end
            send_request(name, 8'($random(seed)));
            wait_drained();
        end
        finish_test(base);

        // Installs at 60..63 never touch the bits probed by queries up to 55
        test_name = "concurrency";
        base = errors;
        for (int k = 0; k < 12; k++) begin
            burst[k] = {$random(seed), $random(seed)};
        end
        random_ready = 1'b1;
        fork
            for (int k = 0; k < 12; k++) begin
                send_data(burst[k], 8'(60 + k % 4));
            end
            for (int k = 0; k < 12; k++) begin
                send_request(64'hA5C3_1E77_0F92_4B68, 8'(k * 5));
            end
        join
        wait_drained();
        random_ready = 1'b0;
        finish_test(base);

        errors = errors + DUT.u_asserts.fail_count;
        $display("Tests run: %0d, tests failed: %0d, errors: %0d",
                 test_count, failed_tests, errors);
        if (failed_tests == 0 && errors == 0 && !timed_out) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

//--- fib_table_top.f
rtl/fib_pkg.sv
rtl/fib_byte_if.sv
rtl/fib_valid_table.sv
rtl/fib_rx_learn.sv
rtl/fib_lpm_lookup.sv
rtl/fib_tx_merge.sv
rtl/fib_table_top.sv
bench/fib_clock_gen.sv
bench/fib_table_asserts.sv
bench/fib_tb.sv

//--- Bender.yml
package:
  name: fib_table

sources:
  - rtl/fib_pkg.sv
  - rtl/fib_byte_if.sv
  - rtl/fib_valid_table.sv
  - rtl/fib_rx_learn.sv
  - rtl/fib_lpm_lookup.sv
  - rtl/fib_tx_merge.sv
  - rtl/fib_table_top.sv
  - target: test
    files:
      - bench/fib_clock_gen.sv
      - bench/fib_table_asserts.sv
      - bench/fib_tb.sv
